// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= dcache_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
src/dcache_pkg.sv
src/dcache_if.sv
src/req_capture.sv
src/dcache_core.sv
src/mem_port.sv
src/dcache_top.sv
tb/dcache_properties.sv
tb/dcache_tb.sv

// File: src/dcache_core.sv
module dcache_core #(
  parameter int addr_w     = dcache_pkg::ADDR_W,
  parameter int word_w     = dcache_pkg::WORD_W,
  parameter int line_words = dcache_pkg::LINE_WORDS,
  parameter int num_lines  = dcache_pkg::NUM_LINES
) (
  input  logic              clk,
  input  logic              rst,
  cpu_req_if.dst            req,
  mem_req_if.core           mem,
  output logic [word_w-1:0] data_out,
  output logic              operation_complete
);

  localparam int line_w     = word_w * line_words;
  localparam int byte_w     = $clog2(word_w / 8);
  localparam int word_sel_w = $clog2(line_words);
  localparam int off_w      = byte_w + word_sel_w;
  localparam int idx_w      = $clog2(num_lines);
  localparam int tag_w      = addr_w - idx_w - off_w;

  dcache_pkg::cache_state_e state;
  dcache_pkg::cache_state_e state_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // arrays and hit detection
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic [num_lines-1:0] line_valid;
  logic [tag_w-1:0]     tag_mem  [num_lines];
  logic [line_w-1:0]    data_mem [num_lines];

  logic [idx_w-1:0]      idx;
  logic [tag_w-1:0]      tag;
  logic [word_sel_w-1:0] word_sel;
  logic                  is_write;
  logic                  hit;
  logic [word_w-1:0]     hit_word;
  logic                  fill;

  // the request fields are held by the input side for the whole operation.
  assign idx      = req.addr[off_w +: idx_w];
  assign tag      = req.addr[addr_w-1 -: tag_w];
  assign word_sel = req.addr[byte_w +: word_sel_w];
  assign is_write = (req.op == dcache_pkg::OP_WRITE);
  assign hit      = line_valid[idx] && (tag_mem[idx] == tag);
  assign hit_word = data_mem[idx][word_sel * word_w +: word_w];  // word 0 sits in the low bits.
  assign fill     = (state == dcache_pkg::FILL_WAIT) && mem.done;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // controller
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next = state;
    case (state)
      dcache_pkg::IDLE: begin
        if (req.valid) state_next = dcache_pkg::LOOKUP;
      end
      dcache_pkg::LOOKUP: begin
        if (is_write) begin
          state_next = dcache_pkg::WRITE_WAIT;
        end else if (hit) begin
          state_next = dcache_pkg::RESPOND;
        end else begin
          state_next = dcache_pkg::FILL_WAIT;
        end
      end
      dcache_pkg::FILL_WAIT: begin
        if (mem.done) state_next = dcache_pkg::LOOKUP;  // replay, now a hit.
      end
      dcache_pkg::WRITE_WAIT: begin
        if (mem.done) state_next = dcache_pkg::RESPOND;
      end
      dcache_pkg::RESPOND: state_next = dcache_pkg::IDLE;
      default: state_next = dcache_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= dcache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign req.idle           = (state == dcache_pkg::IDLE);
  assign operation_complete = (state == dcache_pkg::RESPOND);

  // every write goes out, and so does a read that misses.
  assign mem.start = (state == dcache_pkg::LOOKUP) && (is_write || !hit);
  assign mem.op    = req.op;
  assign mem.addr  = is_write ? req.addr : {req.addr[addr_w-1:off_w], {off_w{1'b0}}};
  assign mem.wdata = req.wdata;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // array and output updates
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (rst) begin
      line_valid <= '0;
    end else if (fill) begin
      line_valid[idx] <= 1'b1;
    end
  end

  // a write miss leaves the line alone, there is no allocation.
  always_ff @(posedge clk) begin
    if (fill) begin
      data_mem[idx] <= mem.line;
      tag_mem[idx]  <= tag;
    end else if ((state == dcache_pkg::LOOKUP) && is_write && hit) begin
      data_mem[idx][word_sel * word_w +: word_w] <= req.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      data_out <= '0;
    end else if ((state == dcache_pkg::LOOKUP) && !is_write && hit) begin
      data_out <= hit_word;  // shows up with operation_complete.
    end
  end

endmodule

// File: src/dcache_if.sv
// one captured processor request, valid for a single cycle.
interface cpu_req_if #(
  parameter int addr_w = dcache_pkg::ADDR_W,
  parameter int word_w = dcache_pkg::WORD_W
);
  logic                  valid;
  dcache_pkg::cache_op_e op;
  logic [addr_w-1:0]     addr;
  logic [word_w-1:0]     wdata;
  logic                  idle;   // core is in IDLE and can take a request.

  modport src (output valid, op, addr, wdata, input idle);
  modport dst (input valid, op, addr, wdata, output idle);
endinterface

// core to memory port, one request in flight at most.
interface mem_req_if #(
  parameter int addr_w = dcache_pkg::ADDR_W,
  parameter int word_w = dcache_pkg::WORD_W,
  parameter int line_w = dcache_pkg::WORD_W * dcache_pkg::LINE_WORDS
);
  logic                  start;  // one-cycle pulse from the core.
  dcache_pkg::cache_op_e op;
  logic [addr_w-1:0]     addr;
  logic [word_w-1:0]     wdata;
  logic                  done;   // one-cycle pulse from the port.
  logic [line_w-1:0]     line;

  modport core (output start, op, addr, wdata, input done, line);
  modport port (input start, op, addr, wdata, output done, line);
endinterface

// File: src/dcache_pkg.sv
package dcache_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // default geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int WORD_W     = 64;  // data word width in bits.
  localparam int ADDR_W     = 32;  // byte address width.
  localparam int LINE_WORDS = 8;   // 512-bit line, 6 offset bits.
  localparam int NUM_LINES  = 16;  // small on purpose, 4 index bits.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // opcodes and controller states
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic {
    OP_READ,
    OP_WRITE
  } cache_op_e;

  // a fill replays through LOOKUP, which then hits.
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    FILL_WAIT,
    WRITE_WAIT,
    RESPOND
  } cache_state_e;

endpackage

// File: src/dcache_top.sv
module dcache_top #(
  parameter int word_w     = dcache_pkg::WORD_W,
  parameter int addr_w     = dcache_pkg::ADDR_W,
  parameter int line_words = dcache_pkg::LINE_WORDS,
  parameter int num_lines  = dcache_pkg::NUM_LINES
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         enable,
  input  logic                         wr_en,
  input  logic [addr_w-1:0]            r_addr,
  input  logic [addr_w-1:0]            w_addr,
  input  logic [word_w-1:0]            data_in,
  input  logic [word_w*line_words-1:0] mem_data_in,
  input  logic                         mem_data_valid,
  output logic [word_w-1:0]            data_out,
  output logic                         operation_complete,
  output logic                         busy,
  output logic [addr_w-1:0]            mem_address,
  output logic [word_w-1:0]            mem_data_out,
  output logic                         mem_wr_en,
  output logic                         mem_req
);

  cpu_req_if #(.addr_w(addr_w), .word_w(word_w)) cpu_bus ();
  mem_req_if #(.addr_w(addr_w), .word_w(word_w), .line_w(word_w * line_words)) mem_bus ();

  req_capture #(.addr_w(addr_w), .word_w(word_w)) u_req (
    .clk(clk), .rst(rst), .enable(enable), .wr_en(wr_en),
    .r_addr(r_addr), .w_addr(w_addr), .data_in(data_in),
    .busy(busy), .req(cpu_bus)
  );

  dcache_core #(
    .addr_w(addr_w), .word_w(word_w), .line_words(line_words), .num_lines(num_lines)
  ) u_core (
    .clk(clk), .rst(rst), .req(cpu_bus), .mem(mem_bus),
    .data_out(data_out), .operation_complete(operation_complete)
  );

  mem_port #(.addr_w(addr_w), .word_w(word_w), .line_words(line_words)) u_mem (
    .clk(clk), .rst(rst), .mem(mem_bus),
    .mem_address(mem_address), .mem_data_out(mem_data_out),
    .mem_wr_en(mem_wr_en), .mem_req(mem_req),
    .mem_data_in(mem_data_in), .mem_data_valid(mem_data_valid)
  );

endmodule

// File: src/mem_port.sv
module mem_port #(
  parameter int addr_w     = dcache_pkg::ADDR_W,
  parameter int word_w     = dcache_pkg::WORD_W,
  parameter int line_words = dcache_pkg::LINE_WORDS
) (
  input  logic                         clk,
  input  logic                         rst,
  mem_req_if.port                      mem,
  output logic [addr_w-1:0]            mem_address,
  output logic [word_w-1:0]            mem_data_out,
  output logic                         mem_wr_en,
  output logic                         mem_req,
  input  logic [word_w*line_words-1:0] mem_data_in,
  input  logic                         mem_data_valid
);

  logic ack;

  // a valid pulse with no request open is not an answer.
  assign ack = mem_req & mem_data_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_req   <= 1'b0;
      mem_wr_en <= 1'b0;
      mem.done  <= 1'b0;
    end else begin
      mem.done <= ack;
      if (mem.start) begin
        mem_req   <= 1'b1;
        mem_wr_en <= (mem.op == dcache_pkg::OP_WRITE);
      end else if (ack) begin
        mem_req   <= 1'b0;
        mem_wr_en <= 1'b0;
      end
    end
  end

  // held steady while the request is open. the core never starts twice.
  always_ff @(posedge clk) begin
    if (mem.start) begin
      mem_address  <= mem.addr;
      mem_data_out <= mem.wdata;
    end
    if (ack) begin
      mem.line <= mem_data_in;  // on a write the core ignores it.
    end
  end

endmodule

// File: src/req_capture.sv
module req_capture #(
  parameter int addr_w = dcache_pkg::ADDR_W,
  parameter int word_w = dcache_pkg::WORD_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              enable,
  input  logic              wr_en,
  input  logic [addr_w-1:0] r_addr,
  input  logic [addr_w-1:0] w_addr,
  input  logic [word_w-1:0] data_in,
  output logic              busy,
  cpu_req_if.src            req
);

  logic accept;

  // busy covers the valid cycle too, before the core leaves IDLE.
  assign busy   = req.valid | ~req.idle;
  assign accept = enable & ~busy;  // strobes seen while busy are dropped.

  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= accept;
    end
  end

  // fields stay put until the next accepted strobe.
  always_ff @(posedge clk) begin
    if (accept) begin
      if (wr_en) begin
        req.op   <= dcache_pkg::OP_WRITE;
        req.addr <= w_addr;
      end else begin
        req.op   <= dcache_pkg::OP_READ;
        req.addr <= r_addr;
      end
      req.wdata <= data_in;
    end
  end

endmodule

// File: tb/dcache_properties.sv
module dcache_properties (
  input logic                              clk,
  input logic                              rst,
  input logic                              enable,
  input logic                              wr_en,
  input logic                              busy,
  input logic                              operation_complete,
  input logic                              mem_req,
  input logic                              mem_wr_en,
  input logic                              mem_data_valid,
  input logic [dcache_pkg::ADDR_W-1:0]     mem_address,
  input logic [dcache_pkg::WORD_W-1:0]     mem_data_out,
  input dcache_pkg::cache_state_e          state
);
  timeunit 1ns;
  timeprecision 1ps;

  logic read_accept;

  assign read_accept = enable && !busy && !wr_en;  // a read taken at this edge.

  single_complete: assert property (@(posedge clk) disable iff (rst)
    operation_complete |=> !operation_complete)
    else $error("operation_complete stayed high for more than one cycle.");

  // the outward request does not move until the memory answers.
  held_request: assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_data_valid |=>
      $stable(mem_address) && $stable(mem_wr_en) && $stable(mem_data_out))
    else $error("memory request changed while it was still open.");

  quiet_after_reset: assert property (@(posedge clk)
    $fell(rst) |-> !busy && !mem_req && !operation_complete)
    else $error("outputs not idle in the first cycle after reset.");

  // a read either completes in three cycles or has gone out to memory by then.
  read_hit_latency: assert property (@(posedge clk) disable iff (rst)
    read_accept |-> ##3 (operation_complete != mem_req))
    else $error("read did not complete three cycles after acceptance nor miss.");

  // the memory port is quiet whenever the controller expects no answer.
  no_stray_request: assert property (@(posedge clk) disable iff (rst)
    state inside {dcache_pkg::IDLE, dcache_pkg::LOOKUP, dcache_pkg::RESPOND} |-> !mem_req)
    else $error("memory request open while the controller expected no answer.");

endmodule

bind dcache_top dcache_properties u_props (
  .clk(clk), .rst(rst), .enable(enable), .wr_en(wr_en), .busy(busy),
  .operation_complete(operation_complete), .mem_req(mem_req), .mem_wr_en(mem_wr_en),
  .mem_data_valid(mem_data_valid), .mem_address(mem_address),
  .mem_data_out(mem_data_out), .state(u_core.state)
);

// File: tb/dcache_tb.sv
module dcache_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_DIRECTED   = 9;
  localparam int NUM_RANDOM     = 200;
  localparam int TIMEOUT_CYCLES = 40 * (NUM_DIRECTED + NUM_RANDOM) + 200;

  logic clk, rst, enable, wr_en, operation_complete, busy, mem_wr_en, mem_req;
  logic [31:0]  r_addr, w_addr, mem_address;
  logic [63:0]  data_in, data_out, mem_data_out, last_read;
  logic         mem_data_valid = 1'b0;
  logic [511:0] mem_data_in = '0;

  logic [31:0] lfsr = 32'h277a0d36;
  logic [63:0] mem_words [logic [28:0]];  // sparse memory, keyed by word address.
  logic [15:0] shadow_valid;
  logic [21:0] shadow_tag [16];
  logic [31:0] exp_mem_addr;
  logic [63:0] exp_mem_data;
  logic        exp_mem_wr;
  logic [2:0]  latency, wait_left;
  bit          serving;
  int unsigned completions = 0;
  int unsigned accepted;
  int unsigned cycle_count;

  dcache_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hA300_0000 : 32'h0);  // one Galois step per bit.
    end
    return v;
  endfunction

  function automatic logic [63:0] mem_word(input logic [31:0] byte_addr);
    logic [28:0] wa;
    wa = byte_addr[31:3];
    if (mem_words.exists(wa)) return mem_words[wa];
    return {35'b0, wa} ^ 64'hA5A5_0000_0000_5A5A;
  endfunction

  // two tags over four indexes, so lines keep evicting each other.
  function automatic logic [31:0] pool_addr(input logic tag_sel, input logic [1:0] idx_sel,
                                            input logic [2:0] word);
    return {tag_sel ? 22'h00_2C7 : 22'h00_113, 2'b01, idx_sel, word, 3'b000};
  endfunction

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic fail_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    $display("** Error: %s expected %h actual %h", name, exp, act);
    abort_run();
  endtask

  task automatic fail_text(input string msg);
    $display("Error: %s", msg);
    abort_run();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always @(posedge clk) begin : memory_model
    logic [511:0] line;
    if (rst) begin
      mem_data_valid <= 1'b0;
      serving = 1'b0;
    end else begin
      mem_data_valid <= 1'b0;
      if (mem_req && !mem_data_valid && !serving) begin  // a new request opened.
        assert (mem_address === exp_mem_addr)
          else fail_value("mem address", 64'(exp_mem_addr), 64'(mem_address));
        assert (mem_wr_en === exp_mem_wr)
          else fail_value("mem write enable", 64'(exp_mem_wr), 64'(mem_wr_en));
        if (exp_mem_wr) begin
          assert (mem_data_out === exp_mem_data)
            else fail_value("mem write data", exp_mem_data, mem_data_out);
        end
        serving = 1'b1;
        wait_left = latency;
      end
      if (serving && wait_left == 3'd0) begin
        if (mem_wr_en) begin
          mem_words[mem_address[31:3]] = mem_data_out;
        end else begin
          for (int w = 0; w < 8; w++) begin
            line[w*64 +: 64] = mem_word({mem_address[31:6], w[2:0], 3'b000});
          end
          mem_data_in <= line;
        end
        mem_data_valid <= 1'b1;
        serving = 1'b0;
      end else if (serving) begin
        wait_left = wait_left - 3'd1;
      end
    end
  end

  always @(posedge clk) begin
    if (operation_complete) completions <= completions + 1;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    fail_text("the run went past its cycle limit without finishing.");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one request, start to completion
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_op(input string name, input logic is_wr, input logic [31:0] addr,
                        input logic [63:0] wdata, input logic noisy);
    logic        exp_hit;
    logic        saw_req;
    logic        done;
    logic [63:0] exp_word;
    logic [63:0] rnd;
    int          cycles;
    exp_hit = shadow_valid[addr[9:6]] && (shadow_tag[addr[9:6]] == addr[31:10]);
    exp_word = mem_word(addr);
    exp_mem_addr = is_wr ? addr : {addr[31:6], 6'b0};  // fills are line aligned.
    exp_mem_wr = is_wr;
    exp_mem_data = wdata;
    rnd = take_bits(3);
    latency = rnd[2:0];
    saw_req = 1'b0;
    cycles = 0;
    @(posedge clk);
    enable <= 1'b1;
    wr_en <= is_wr;
    w_addr <= is_wr ? addr : ~addr;  // the unused address port carries junk.
    r_addr <= is_wr ? ~addr : addr;
    data_in <= wdata;
    @(negedge clk);
    assert (completions == accepted)
      else fail_value({name, " completion count"}, 64'(accepted), 64'(completions));
    assert (!busy) else fail_text("busy was high when a new request was due.");
    accepted++;
    @(posedge clk);
    enable <= 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      cycles++;
      saw_req = saw_req | mem_req;
      done = operation_complete;
      if (!done && noisy) begin
        @(posedge clk);
        rnd = take_bits(2);
        enable <= rnd[0];  // strobes while busy must be dropped.
        wr_en <= rnd[1];
        rnd = take_bits(64);
        r_addr <= rnd[31:0];
        w_addr <= rnd[63:32];
        data_in <= ~rnd;
      end
    end
    if (is_wr) begin
      assert (saw_req) else fail_text("a write never reached the memory port.");
      assert (data_out === last_read) else fail_value({name, " data held"}, last_read, data_out);
    end else begin
      assert (saw_req === !exp_hit) else fail_value({name, " miss"}, 64'(!exp_hit), 64'(saw_req));
      assert (data_out === exp_word) else fail_value(name, exp_word, data_out);
      if (exp_hit) begin
        assert (cycles == 3) else fail_value({name, " hit latency"}, 64'd3, 64'(cycles));
      end
      last_read = exp_word;
      shadow_valid[addr[9:6]] = 1'b1;
      shadow_tag[addr[9:6]] = addr[31:10];
    end
  endtask

  initial begin
    logic [63:0] r;
    logic [63:0] wdata;
    logic [31:0] a_addr, b_addr, c_addr;
    rst = 1'b1;
    enable = 1'b0;
    wr_en = 1'b0;
    r_addr = '0;
    w_addr = '0;
    data_in = '0;
    shadow_valid = '0;
    last_read = '0;
    accepted = 0;
    a_addr = pool_addr(1'b0, 2'd1, 3'd2);
    b_addr = pool_addr(1'b0, 2'd2, 3'd5);
    c_addr = pool_addr(1'b1, 2'd1, 3'd2);  // same index as a_addr.
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    run_op("cold read", 1'b0, a_addr, 64'd0, 1'b0);
    run_op("same line read", 1'b0, pool_addr(1'b0, 2'd1, 3'd3), 64'd0, 1'b0);
    run_op("repeat read", 1'b0, a_addr, 64'd0, 1'b0);
    run_op("write hit", 1'b1, a_addr, 64'h0123_4567_89AB_CDEF, 1'b0);
    run_op("read after write hit", 1'b0, a_addr, 64'd0, 1'b0);
    run_op("write miss", 1'b1, b_addr, 64'hFEDC_BA98_7654_3210, 1'b0);
    run_op("read after write miss", 1'b0, b_addr, 64'd0, 1'b0);
    run_op("evicting read", 1'b0, c_addr, 64'd0, 1'b0);
    run_op("read after eviction", 1'b0, a_addr, 64'd0, 1'b0);
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r = take_bits(7);
      wdata = take_bits(64);
      run_op("random op", r[6], pool_addr(r[0], r[2:1], r[5:3]), wdata, 1'b1);
    end
    @(posedge clk);
    enable <= 1'b0;
    repeat (4) @(negedge clk);
    if (completions == accepted) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      fail_value("final completion count", 64'(accepted), 64'(completions));
    end
  end

endmodule
